//--- build.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module adxl_bridge_tb -f list.f -o adxl_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/adxl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "^No errors$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- hdl/adxl_bridge.sv
`timescale 1ns/1ns

module adxl_bridge (
    input  logic                     CLK,
    input  logic                     RESETN,
    input  logic                     dev_wr_en,
    input  adxl_regmap_pkg::reg_wr_t dev_wr,
    input  logic                     dev_rd_en,
    input  logic [3:0]               dev_rd_word,
    output logic [31:0]              dev_rd_data,
    output logic                     dev_rd_done,
    input  logic                     cfg_wr_en,
    input  adxl_regmap_pkg::reg_wr_t cfg_wr,
    input  logic                     cfg_rd_en,
    input  logic [2:0]               cfg_rd_word,
    output logic [31:0]              cfg_rd_data,
    output logic                     cfg_rd_done,
    output logic                     cmd_valid,
    output adxl_link_pkg::cmd_beat_t cmd,
    input  logic                     cmd_ready,
    input  logic                     rsp_valid,
    input  adxl_link_pkg::rsp_beat_t rsp,
    input  logic                     adxl_interrupt,
    output logic                     adxl_irq
);
    import adxl_regmap_pkg::*;
    import adxl_link_pkg::*;

    sensor_addr_t scan_addr;
    logic         pending_clear;
    logic         any_pending;
    logic         scan_pending;
    logic [7:0]   scan_byte;
    logic         capture_en;
    capture_t     capture;
    cfg_ctrl_t    ctrl;
    logic [31:0]  request_interval;
    logic         busy;
    logic         push;
    cmd_beat_t    push_beat;
    logic         afull;

    adxl_shadow_regs u_shadow (
        .CLK(CLK), .RESETN(RESETN),
        .wr_en(dev_wr_en), .wr(dev_wr), .rd_en(dev_rd_en), .rd_word(dev_rd_word),
        .rd_data(dev_rd_data), .rd_done(dev_rd_done),
        .scan_addr(scan_addr), .pending_clear(pending_clear), .scan_pending(scan_pending),
        .scan_byte(scan_byte), .any_pending(any_pending),
        .capture_en(capture_en), .capture(capture)
    );

    adxl_cfg_regs u_cfg (
        .CLK(CLK), .RESETN(RESETN),
        .wr_en(cfg_wr_en), .wr(cfg_wr), .rd_en(cfg_rd_en), .rd_word(cfg_rd_word),
        .rd_data(cfg_rd_data), .rd_done(cfg_rd_done),
        .capture_en(capture_en), .capture(capture), .busy(busy),
        .adxl_interrupt(adxl_interrupt), .ctrl(ctrl),
        .request_interval(request_interval), .adxl_irq(adxl_irq)
    );

    adxl_sequencer u_seq (
        .CLK(CLK), .RESETN(RESETN),
        .ctrl(ctrl), .request_interval(request_interval),
        .any_pending(any_pending), .scan_pending(scan_pending), .scan_byte(scan_byte),
        .afull(afull), .rsp_valid(rsp_valid), .rsp(rsp),
        .scan_addr(scan_addr), .pending_clear(pending_clear),
        .push(push), .push_beat(push_beat),
        .capture_en(capture_en), .capture(capture), .busy(busy)
    );

    adxl_cmd_queue u_queue (
        .CLK(CLK), .RESETN(RESETN),
        .push(push), .push_beat(push_beat), .afull(afull),
        .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready)
    );

endmodule

//--- hdl/adxl_cfg_regs.sv
`timescale 1ns/1ns

module adxl_cfg_regs (
    input  logic                       CLK,
    input  logic                       RESETN,
    input  logic                       wr_en,
    input  adxl_regmap_pkg::reg_wr_t   wr,
    input  logic                       rd_en,
    input  logic [2:0]                 rd_word,
    output logic [31:0]                rd_data,
    output logic                       rd_done,
    input  logic                       capture_en,
    input  adxl_link_pkg::capture_t    capture,
    input  logic                       busy,
    input  logic                       adxl_interrupt,
    output adxl_regmap_pkg::cfg_ctrl_t ctrl,
    output logic [31:0]                request_interval,
    output logic                       adxl_irq
);
    import adxl_regmap_pkg::*;
    import adxl_link_pkg::*;

    logic        link_on;
    logic [31:0] word0;
    logic [31:0] rd_mux;

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            ctrl             <= '{enable: 1'b0, allow_irq: 1'b0, i2c_address: DEFAULT_I2C_ADDR};
            request_interval <= DEFAULT_INTERVAL;
            link_on          <= 1'b0;
            adxl_irq         <= 1'b0;
            rd_done          <= 1'b0;
        end else begin
            if (wr_en && wr.word == 4'd0) begin
                if (wr.strb[0]) begin
                    ctrl.enable    <= wr.data[CFG_ENABLE_BIT];
                    ctrl.allow_irq <= wr.data[CFG_IRQ_BIT];
                end
                if (wr.strb[1]) begin
                    ctrl.i2c_address <= wr.data[CFG_ADDR_LSB +: 7];
                end
            end
            if (wr_en && wr.word == 4'd1) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr.strb[b]) begin
                        request_interval[8*b +: 8] <= wr.data[8*b +: 8];
                    end
                end
            end
            if (capture_en && capture.addr == '0) begin
                link_on <= (capture.data == DEVICE_ID);  // devid answers 0xe5
            end
            adxl_irq <= adxl_interrupt & ctrl.allow_irq & ctrl.enable;
            rd_done  <= rd_en;
        end
    end

    always_comb begin
        word0                          = '0;
        word0[CFG_ENABLE_BIT]          = ctrl.enable;
        word0[CFG_IRQ_BIT]             = ctrl.allow_irq;
        word0[CFG_BUSY_BIT]            = busy;
        word0[CFG_ADDR_LSB +: 7]       = ctrl.i2c_address;
        word0[CFG_LINK_BIT]            = link_on;
        word0[CFG_MINOR_LSB +: 8]      = VERSION_MINOR;
        word0[CFG_MAJOR_LSB +: 8]      = VERSION_MAJOR;
        case (rd_word)
            3'd0:    rd_mux = word0;
            3'd1:    rd_mux = request_interval;
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rd_en) begin
            rd_data <= rd_mux;
        end
    end

endmodule

//--- hdl/adxl_cmd_queue.sv
`timescale 1ns/1ns

module adxl_cmd_queue (
    input  logic                     CLK,
    input  logic                     RESETN,
    input  logic                     push,
    input  adxl_link_pkg::cmd_beat_t push_beat,
    output logic                     afull,
    output logic                     cmd_valid,
    output adxl_link_pkg::cmd_beat_t cmd,
    input  logic                     cmd_ready
);
    import adxl_link_pkg::*;

    cmd_beat_t            mem [CMD_DEPTH];
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_PTR_W:0]   count;
    logic                 pop;

    assign pop = cmd_valid && cmd_ready;

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    assign cmd_valid = (count != '0);
    assign cmd       = mem[rd_ptr];
    assign afull     = (CMD_DEPTH - int'(count)) < CMD_AFULL_SLACK;  // room for a whole command

endmodule

//--- hdl/adxl_link_pkg.sv
package adxl_link_pkg;

    typedef struct packed {
        logic [7:0] data;
        logic [7:0] user;   // i2c address then read bit
        logic       last;
    } cmd_beat_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } rsp_beat_t;

    typedef struct packed {
        adxl_regmap_pkg::sensor_addr_t addr;
        logic [7:0]                    data;
    } capture_t;

    localparam logic [7:0] OP_WRITE   = 8'h02;
    localparam logic [7:0] OP_POINTER = 8'h01;
    localparam logic [7:0] DEVICE_ID  = 8'hE5;

    localparam int CMD_DEPTH       = 16;
    localparam int CMD_AFULL_SLACK = 4;
    localparam int CMD_PTR_W       = $clog2(CMD_DEPTH);

endpackage

//--- hdl/adxl_regmap_pkg.sv
package adxl_regmap_pkg;

    typedef logic [5:0] sensor_addr_t;

    localparam int SENSOR_BYTES = 'h3A;
    localparam int SENSOR_WORDS = 16;
    localparam sensor_addr_t READ_LAST_ADDR = 6'h39;

    // one bit per byte, bit 0 is the lowest address of the word
    localparam logic [SENSOR_WORDS-1:0][3:0] WRITE_MASK = {
        4'b0000,    // 0x3c
        4'b0001,    // 0x38 fifo_ctl
        4'b0000,    // 0x34
        4'b0010,    // 0x30 data_format at 0x31
        4'b1111,    // 0x2c bw_rate .. int_map
        4'b0111,    // 0x28
        4'b1111,    // 0x24
        4'b1111,    // 0x20
        4'b1110,    // 0x1c thresh_tap and offsets
        4'b0000,
        4'b0000,
        4'b0000,
        4'b0000,
        4'b0000,
        4'b0000,
        4'b0000     // 0x00 devid, read only
    };

    typedef struct packed {
        logic [3:0]  word;
        logic [31:0] data;
        logic [3:0]  strb;
    } reg_wr_t;

    typedef struct packed {
        logic       enable;
        logic       allow_irq;
        logic [6:0] i2c_address;
    } cfg_ctrl_t;

    localparam int CFG_ENABLE_BIT = 1;
    localparam int CFG_IRQ_BIT    = 2;
    localparam int CFG_BUSY_BIT   = 4;
    localparam int CFG_ADDR_LSB   = 8;
    localparam int CFG_LINK_BIT   = 15;
    localparam int CFG_MINOR_LSB  = 16;
    localparam int CFG_MAJOR_LSB  = 24;

    localparam logic [7:0]  VERSION_MINOR    = 8'd2;
    localparam logic [7:0]  VERSION_MAJOR    = 8'd1;
    localparam logic [6:0]  DEFAULT_I2C_ADDR = 7'h53;
    localparam logic [31:0] DEFAULT_INTERVAL = 32'd1000;

endpackage

//--- hdl/adxl_sequencer.sv
`timescale 1ns/1ns

module adxl_sequencer (
    input  logic                          CLK,
    input  logic                          RESETN,
    input  adxl_regmap_pkg::cfg_ctrl_t    ctrl,
    input  logic [31:0]                   request_interval,
    input  logic                          any_pending,
    input  logic                          scan_pending,
    input  logic [7:0]                    scan_byte,
    input  logic                          afull,
    input  logic                          rsp_valid,
    input  adxl_link_pkg::rsp_beat_t      rsp,
    output adxl_regmap_pkg::sensor_addr_t scan_addr,
    output logic                          pending_clear,
    output logic                          push,
    output adxl_link_pkg::cmd_beat_t      push_beat,
    output logic                          capture_en,
    output adxl_link_pkg::capture_t       capture,
    output logic                          busy
);
    import adxl_regmap_pkg::*;
    import adxl_link_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_CHECK, S_SEND_WRITE, S_NEXT_ADDR, S_SEND_POINTER, S_READ_REQ, S_AWAIT
    } state_t;

    state_t       state;
    sensor_addr_t addr;     // scan address, then capture address
    logic [1:0]   beat_cnt;
    logic [31:0]  timer;

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state    <= S_IDLE;
            addr     <= '0;
            beat_cnt <= '0;
            timer    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    addr     <= '0;
                    beat_cnt <= '0;
                    if (!ctrl.enable) begin
                        timer <= '0;
                    end else if (any_pending) begin
                        state <= S_CHECK;
                    end else if (timer >= request_interval) begin
                        timer <= '0;
                        state <= S_SEND_POINTER;
                    end else begin
                        timer <= timer + 32'd1;
                    end
                end
                S_CHECK: state <= scan_pending ? S_SEND_WRITE : S_NEXT_ADDR;
                S_SEND_WRITE: begin
                    if (!afull) begin
                        beat_cnt <= (beat_cnt == 2'd2) ? 2'd0 : beat_cnt + 2'd1;
                        if (beat_cnt == 2'd2) begin
                            state <= S_NEXT_ADDR;
                        end
                    end
                end
                S_NEXT_ADDR: begin
                    if (addr == READ_LAST_ADDR) begin
                        state <= S_IDLE;
                    end else begin
                        addr  <= addr + 6'd1;
                        state <= S_CHECK;
                    end
                end
                S_SEND_POINTER: begin
                    if (!afull) begin
                        beat_cnt <= (beat_cnt == 2'd1) ? 2'd0 : beat_cnt + 2'd1;
                        if (beat_cnt == 2'd1) begin
                            state <= S_READ_REQ;
                        end
                    end
                end
                S_READ_REQ: if (!afull) state <= S_AWAIT;
                S_AWAIT: begin
                    if (rsp_valid) begin
                        addr <= addr + 6'd1;
                        if (rsp.last) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        push           = 1'b0;
        push_beat      = '0;
        push_beat.user = {ctrl.i2c_address, 1'b0};
        case (state)
            S_SEND_WRITE: begin
                push = !afull;
                case (beat_cnt)
                    2'd0:    push_beat.data = OP_WRITE;
                    2'd1:    push_beat.data = {2'b00, addr};
                    default: begin
                        push_beat.data = scan_byte;
                        push_beat.last = 1'b1;
                    end
                endcase
            end
            S_SEND_POINTER: begin
                push           = !afull;
                push_beat.data = (beat_cnt == 2'd0) ? OP_POINTER : 8'h00;
                push_beat.last = (beat_cnt != 2'd0);
            end
            S_READ_REQ: begin
                push           = !afull;
                push_beat.data = {2'b00, READ_LAST_ADDR};
                push_beat.user = {ctrl.i2c_address, 1'b1};  // read bit
                push_beat.last = 1'b1;
            end
            default: ;
        endcase
    end

    assign pending_clear = (state == S_SEND_WRITE) && !afull && (beat_cnt == 2'd2);
    assign scan_addr     = addr;
    assign capture_en    = (state == S_AWAIT) && rsp_valid;
    assign capture       = '{addr: addr, data: rsp.data};
    assign busy          = (state != S_IDLE) || ctrl.enable;

endmodule

//--- hdl/adxl_shadow_regs.sv
`timescale 1ns/1ns

module adxl_shadow_regs (
    input  logic                          CLK,
    input  logic                          RESETN,
    input  logic                          wr_en,
    input  adxl_regmap_pkg::reg_wr_t      wr,
    input  logic                          rd_en,
    input  logic [3:0]                    rd_word,
    output logic [31:0]                   rd_data,
    output logic                          rd_done,
    input  adxl_regmap_pkg::sensor_addr_t scan_addr,
    input  logic                          pending_clear,
    output logic                          scan_pending,
    output logic [7:0]                    scan_byte,
    output logic                          any_pending,
    input  logic                          capture_en,
    input  adxl_link_pkg::capture_t       capture
);
    import adxl_regmap_pkg::*;

    logic [SENSOR_WORDS-1:0][3:0][7:0] mem;
    logic [SENSOR_WORDS-1:0][3:0]      pending;
    logic                              cap_ok;

    assign cap_ok = capture_en && (int'(capture.addr) < SENSOR_BYTES) &&
                    !pending[capture.addr[5:2]][capture.addr[1:0]];   // local edit not yet sent

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            mem     <= '0;
            pending <= '0;
        end else begin
            if (pending_clear) begin
                pending[scan_addr[5:2]][scan_addr[1:0]] <= 1'b0;
            end
            if (cap_ok) begin
                mem[capture.addr[5:2]][capture.addr[1:0]] <= capture.data;
            end
            // host write last so it wins over clear and capture
            if (wr_en) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr.strb[b] && WRITE_MASK[wr.word][b]) begin
                        mem[wr.word][b]     <= wr.data[8*b +: 8];
                        pending[wr.word][b] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            rd_done <= 1'b0;
        end else begin
            rd_done <= rd_en;
        end
    end

    always_ff @(posedge CLK) begin
        if (rd_en) begin
            rd_data <= mem[rd_word];
        end
    end

    assign scan_pending = pending[scan_addr[5:2]][scan_addr[1:0]];
    assign scan_byte    = mem[scan_addr[5:2]][scan_addr[1:0]];
    assign any_pending  = |pending;

endmodule

//--- list.f
hdl/adxl_regmap_pkg.sv
hdl/adxl_link_pkg.sv
hdl/adxl_shadow_regs.sv
hdl/adxl_cfg_regs.sv
hdl/adxl_sequencer.sv
hdl/adxl_cmd_queue.sv
hdl/adxl_bridge.sv
verification/adxl_bridge_props.sv
verification/adxl_bridge_tb.sv

//--- verification/adxl_bridge_props.sv
`timescale 1ns/1ns

module adxl_bridge_props (
    input logic        CLK,
    input logic        RESETN,
    input logic        cmd_valid,
    input logic        cmd_ready,
    input logic [16:0] cmd,
    input logic        dev_rd_done,
    input logic        cfg_rd_done,
    input logic        enable,
    input logic        adxl_irq
);
    a_cmd_hold: assert property (@(posedge CLK) disable iff (!RESETN)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else $error("command beat changed while waiting for ready");

    a_dev_done: assert property (@(posedge CLK) disable iff (!RESETN)
        dev_rd_done |=> !dev_rd_done) else $error("dev_rd_done longer than one cycle");

    a_cfg_done: assert property (@(posedge CLK) disable iff (!RESETN)
        cfg_rd_done |=> !cfg_rd_done) else $error("cfg_rd_done longer than one cycle");

    a_irq_off: assert property (@(posedge CLK) disable iff (!RESETN)
        !enable && $past(!enable) |-> !adxl_irq) else $error("adxl_irq high while disabled");
endmodule

bind adxl_bridge adxl_bridge_props u_props (
    .CLK(CLK), .RESETN(RESETN), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .cmd(cmd), .dev_rd_done(dev_rd_done), .cfg_rd_done(cfg_rd_done),
    .enable(ctrl.enable), .adxl_irq(adxl_irq)
);

//--- verification/adxl_bridge_tb.sv
`timescale 1ns/1ns

module adxl_bridge_tb;
    import adxl_regmap_pkg::*;
    import adxl_link_pkg::*;

    logic CLK, RESETN, dev_wr_en, dev_rd_en, dev_rd_done, cfg_wr_en, cfg_rd_en, cfg_rd_done;
    logic cmd_valid, cmd_ready, rsp_valid, adxl_interrupt, adxl_irq;
    logic        ready_hold;
    reg_wr_t     dev_wr, cfg_wr;
    logic [3:0]  dev_rd_word;
    logic [2:0]  cfg_rd_word;
    logic [31:0] dev_rd_data, cfg_rd_data, seed, rnd;
    cmd_beat_t   cmd;
    rsp_beat_t   rsp;

    logic [7:0] exp_mem [64];
    logic       exp_pend [64];
    cmd_beat_t  exp_q [$];
    cmd_beat_t  exp_beat;
    logic       m_enable, m_allow, m_link, irq_exp;
    logic [6:0] m_addr;

    adxl_bridge u_adxl_bridge (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic logic writable(input int a);
        return (a >= 'h1D && a <= 'h2A) || (a >= 'h2C && a <= 'h2F) || a == 'h31 || a == 'h38;
    endfunction

    // busy equals enable while the sequencer is idle
    function automatic logic [31:0] cfg_word0_model();
        return {8'h01, 8'h02, m_link, m_addr, 3'b000, m_enable, 1'b0, m_allow, m_enable, 1'b0};
    endfunction

    // expected write beats for every pending byte, lowest address first
    function automatic void scan_model();
        for (int a = 0; a < 'h3A; a++) begin
            if (exp_pend[a]) begin
                exp_q.push_back('{data: OP_WRITE, user: {m_addr, 1'b0}, last: 1'b0});
                exp_q.push_back('{data: 8'(a), user: {m_addr, 1'b0}, last: 1'b0});
                exp_q.push_back('{data: exp_mem[a], user: {m_addr, 1'b0}, last: 1'b1});
                exp_pend[a] = 1'b0;
            end
        end
    endfunction

    always @(negedge CLK) begin   // random ready and interrupt
        rnd = $random(seed);
        cmd_ready <= !ready_hold && (rnd[3:0] >= 4'd12);   // long low stretches
        adxl_interrupt <= rnd[8];
    end

    always @(posedge CLK) begin
        if (!RESETN) begin
            m_enable = 1'b0;
            m_allow  = 1'b0;
            irq_exp  = 1'b0;
            m_addr   = 7'h53;
        end else begin
            irq_exp = adxl_interrupt & m_allow & m_enable;
            if (cfg_wr_en && cfg_wr.word == 4'd0 && cfg_wr.strb[0])
                {m_allow, m_enable} = cfg_wr.data[2:1];
            if (cfg_wr_en && cfg_wr.word == 4'd0 && cfg_wr.strb[1])
                m_addr = cfg_wr.data[14:8];
            if (cmd_valid && cmd_ready) begin
                assert (exp_q.size() != 0) else stop_run("command beat seen when none was expected");
                exp_beat = exp_q.pop_front();
                assert (cmd == exp_beat)
                    else stop_run($sformatf("error cmd expected %h got %h", exp_beat, cmd));
            end
        end
    end

    always @(negedge CLK) begin
        if (RESETN) begin
            assert (adxl_irq == irq_exp)
                else stop_run($sformatf("error adxl_irq expected %h got %h", irq_exp, adxl_irq));
        end
    end

    task automatic dev_write(input logic [3:0] w, input logic [31:0] d, input logic [3:0] s);
        @(negedge CLK);
        dev_wr_en = 1'b1;
        dev_wr    = '{word: w, data: d, strb: s};
        for (int b = 0; b < 4; b++) begin
            if (s[b] && writable(4*w + b)) begin
                exp_mem[4*w + b]  = d[8*b +: 8];
                exp_pend[4*w + b] = 1'b1;
            end
        end
        @(negedge CLK);
        dev_wr_en = 1'b0;
    endtask

    task automatic cfg_write(input logic [3:0] w, input logic [31:0] d, input logic [3:0] s);
        @(negedge CLK);
        cfg_wr_en = 1'b1;
        cfg_wr    = '{word: w, data: d, strb: s};
        @(negedge CLK);
        cfg_wr_en = 1'b0;
    endtask

    task automatic dev_read_check(input logic [3:0] w);
        int n = 0;
        logic [31:0] exp_w;
        @(negedge CLK);
        dev_rd_en   = 1'b1;
        dev_rd_word = w;
        @(negedge CLK);
        dev_rd_en = 1'b0;
        while (!dev_rd_done) begin
            if (++n > 50) stop_run("timeout waiting for dev_rd_done");
            @(negedge CLK);
        end
        exp_w = {exp_mem[4*w+3], exp_mem[4*w+2], exp_mem[4*w+1], exp_mem[4*w]};
        assert (dev_rd_data == exp_w)
            else stop_run($sformatf("error dev_rd_data expected %h got %h", exp_w, dev_rd_data));
    endtask

    task automatic cfg_read_check(input logic [2:0] w, input logic [31:0] exp_w);
        int n = 0;
        @(negedge CLK);
        cfg_rd_en   = 1'b1;
        cfg_rd_word = w;
        @(negedge CLK);
        cfg_rd_en = 1'b0;
        while (!cfg_rd_done) begin
            if (++n > 50) stop_run("timeout waiting for cfg_rd_done");
            @(negedge CLK);
        end
        assert (cfg_rd_data == exp_w)
            else stop_run($sformatf("error cfg_rd_data expected %h got %h", exp_w, cfg_rd_data));
    endtask

    task automatic wait_drain();
        int n = 0;
        while (exp_q.size() != 0 || cmd_valid) begin
            if (++n > 20000) stop_run("timeout waiting for the expected command beats");
            @(negedge CLK);
        end
    endtask

    task automatic read_cycle(input logic [7:0] id);
        logic [7:0] d;
        exp_q.push_back('{data: OP_POINTER, user: {m_addr, 1'b0}, last: 1'b0});
        exp_q.push_back('{data: 8'h00, user: {m_addr, 1'b0}, last: 1'b1});
        exp_q.push_back('{data: 8'h39, user: {m_addr, 1'b1}, last: 1'b1});
        cfg_write(4'd1, 32'd20, 4'hF);
        wait_drain();
        cfg_write(4'd1, 32'hFFFF_FFFF, 4'hF);   // no further read cycle
        dev_write(4'd14, {24'h0, id ^ 8'h3C}, 4'h1);    // 0x38 stays pending
        for (int a = 0; a < 'h3A; a++) begin
            d = (a == 0) ? id : (8'(a) * 8'd7) ^ id;
            @(negedge CLK);
            rsp_valid = 1'b1;
            rsp       = '{data: d, last: (a == 'h39)};
            if (!exp_pend[a]) exp_mem[a] = d;
        end
        @(negedge CLK);
        rsp_valid = 1'b0;
        m_link    = (id == 8'hE5);
        scan_model();
        wait_drain();
        cfg_read_check(3'd0, cfg_word0_model());
        for (int w = 0; w < 15; w++) dev_read_check(4'(w));
    endtask

    initial begin
        seed = 32'h7705_51f4;
        ready_hold = 1'b0;
        {dev_wr_en, dev_rd_en, cfg_wr_en, cfg_rd_en, rsp_valid, cmd_ready} = '0;
        {dev_wr, cfg_wr, dev_rd_word, cfg_rd_word, rsp, adxl_interrupt, m_link} = '0;
        for (int a = 0; a < 64; a++) {exp_mem[a], exp_pend[a]} = '0;
        RESETN = 1'b0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESETN = 1'b1;
        cfg_write(4'd0, 32'h0000_1A00, 4'h3);   // new address, still disabled
        dev_write(4'd7, 32'h4433_2211, 4'hF);
        dev_write(4'd0, 32'hDEAD_BEEF, 4'hF);   // read only word
        dev_write(4'd10, 32'hCCBB_AA99, 4'hF);  // 0x2b is read only
        dev_write(4'd12, 32'h8877_6655, 4'hF);
        dev_read_check(4'd0);
        dev_read_check(4'd7);
        dev_read_check(4'd10);
        scan_model();
        ready_hold <= 1'b1;
        cfg_write(4'd0, 32'h0000_1A06, 4'h3);
        repeat (60) @(negedge CLK);   // queue fills up, sequencer stalls on afull
        ready_hold <= 1'b0;
        wait_drain();
        read_cycle(8'hE5);
        read_cycle(8'h3C);
        cfg_write(4'd0, 32'h0000_1A00, 4'h1);
        cfg_read_check(3'd0, cfg_word0_model());   // busy drops with enable
        cfg_read_check(3'd1, 32'hFFFF_FFFF);
        repeat (20) @(negedge CLK);
        $display("No errors");
        $finish;
    end

endmodule
